// ==== Makefile ====
VERILATOR ?= verilator
TOP       := tb_softcore_uncore
FILELIST  := build.f
FLAGS     := --timing --assert
BUILD_DIR := obj_dir
LOG       := sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "Simulation PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== build.f ====
verilog/uncore_pkg.sv
verilog/mem_msg_queue.sv
verilog/mem_cmd_router.sv
verilog/mem_resp_router.sv
verilog/clint_slice.sv
verilog/softcore_uncore.sv
testbench/uncore_properties.sv
testbench/tb_softcore_uncore.sv

// ==== testbench/tb_softcore_uncore.sv ====
`timescale 1ns/1ps

module tb_softcore_uncore;

  import uncore_pkg::*;

  localparam int NUM_REQ = 3;
  localparam logic [15:0] CLINT_HI = 16'h0010;
  localparam int DRAIN_LIMIT = 4000;

  logic                   clk = 1'b0;
  logic                   arst_n = 1'b1;
  mem_msg_t [NUM_REQ-1:0] req_cmd = '0;
  logic     [NUM_REQ-1:0] req_cmd_v = '0;
  logic     [NUM_REQ-1:0] req_cmd_ready;
  mem_msg_t [NUM_REQ-1:0] req_resp;
  logic     [NUM_REQ-1:0] req_resp_v;
  logic     [NUM_REQ-1:0] req_resp_ready = '1;
  mem_msg_t               io_cmd;
  logic                   io_cmd_v;
  logic                   io_cmd_ready;
  mem_msg_t               io_resp = '0;
  logic                   io_resp_v = 1'b0;
  logic                   io_resp_ready;
  mem_msg_t               mem_cmd;
  logic                   mem_cmd_v;
  logic                   mem_cmd_ready;
  mem_msg_t               mem_resp = '0;
  logic                   mem_resp_v = 1'b0;
  logic                   mem_resp_ready;
  logic                   timer_irq;
  logic                   software_irq;

  // Target model state
  logic io_busy = 1'b0;
  logic mem_busy = 1'b0;
  logic mem_stall = 1'b0;
  // Random requester response back-pressure
  logic resp_throttle = 1'b0;

  // Handshakes seen at the falling edge, acted on after the next rising edge
  logic [NUM_REQ-1:0] cmd_fire = '0;
  logic               io_fire = 1'b0;
  logic               mem_fire = 1'b0;
  logic               io_rfire = 1'b0;
  logic               mem_rfire = 1'b0;
  mem_msg_t           io_cmd_s;
  mem_msg_t           mem_cmd_s;

  mem_msg_t cmd_src [NUM_REQ][$];
  mem_msg_t cmd_exp [NUM_REQ][$];
  mem_msg_t resp_exp [NUM_REQ][$];
  bit       data_known [NUM_REQ][$];
  dword_t   last_data [NUM_REQ];

  // Shadow copies of the writable CLINT registers
  logic   msip_sh = 1'b0;
  dword_t mtimecmp_sh = '1;

  int errors = 0;
  int checks = 0;
  int tgt_count = 0;
  int resp_count = 0;

  assign io_cmd_ready  = ~io_busy;
  assign mem_cmd_ready = ~mem_busy & ~mem_stall;

  always #20 clk = ~clk;

  softcore_uncore #(.NUM_REQ(NUM_REQ)) uut
    (.clk_i(clk)
     , .arst_n_i(arst_n)
     , .req_cmd_i(req_cmd)
     , .req_cmd_v_i(req_cmd_v)
     , .req_cmd_ready_o(req_cmd_ready)
     , .req_resp_o(req_resp)
     , .req_resp_v_o(req_resp_v)
     , .req_resp_ready_i(req_resp_ready)
     , .io_cmd_o(io_cmd)
     , .io_cmd_v_o(io_cmd_v)
     , .io_cmd_ready_i(io_cmd_ready)
     , .io_resp_i(io_resp)
     , .io_resp_v_i(io_resp_v)
     , .io_resp_ready_o(io_resp_ready)
     , .mem_cmd_o(mem_cmd)
     , .mem_cmd_v_o(mem_cmd_v)
     , .mem_cmd_ready_i(mem_cmd_ready)
     , .mem_resp_i(mem_resp)
     , .mem_resp_v_i(mem_resp_v)
     , .mem_resp_ready_o(mem_resp_ready)
     , .timer_irq_o(timer_irq)
     , .software_irq_o(software_irq)
     );

  // 0 is the CLINT, 1 the I/O port, 2 memory
  function automatic int ref_target(paddr_t addr);
    logic [3:0] dev;
    dev = addr[DEV_LSB +: 4];
    if (addr >= LOCAL_LIMIT)
      return 2;
    if (dev == CLINT_DEV)
      return 0;
    if (dev == HOST_DEV)
      return 1;
    return 2;
  endfunction

  function automatic dword_t ref_data(mem_msg_t m, int tgt);
    if (m.op == e_mem_wr)
      return m.data;
    if (tgt != 0)
      return {m.addr, ~m.addr};
    case (m.addr[15:0])
      MSIP_OFFSET:     return {63'd0, msip_sh};
      MTIMECMP_OFFSET: return mtimecmp_sh;
      default:         return '0;
    endcase
  endfunction

  function automatic mem_msg_t model_resp(mem_msg_t c);
    mem_msg_t r;
    r = c;
    if (c.op == e_mem_rd)
      r.data = {c.addr, ~c.addr};
    return r;
  endfunction

  function automatic bit all_done();
    bit d;
    d = !io_busy && !mem_busy;
    for (int i = 0; i < NUM_REQ; i++)
      d &= (cmd_src[i].size() == 0) && (resp_exp[i].size() == 0);
    return d;
  endfunction

  function automatic void send_cmd(int r, mem_op_e op, paddr_t addr, dword_t data);
    mem_msg_t m;
    mem_msg_t e;
    int       tgt;
    m.op     = op;
    m.addr   = addr;
    m.lce_id = lce_id_t'(r);
    m.data   = data;
    tgt      = ref_target(addr);
    e        = m;
    e.data   = ref_data(m, tgt);
    if (tgt != 0)
      cmd_exp[r].push_back(m);
    resp_exp[r].push_back(e);
    // mtime moves on its own, so only the CLINT test judges it
    data_known[r].push_back(!(tgt == 0 && op == e_mem_rd && addr[15:0] == MTIME_OFFSET));
    if (tgt == 0 && op == e_mem_wr && addr[15:0] == MSIP_OFFSET)
      msip_sh = data[0];
    if (tgt == 0 && op == e_mem_wr && addr[15:0] == MTIMECMP_OFFSET)
      mtimecmp_sh = data;
    cmd_src[r].push_back(m);
  endfunction

  task automatic random_cmds(int r, int n);
    paddr_t  a;
    mem_op_e op;
    for (int k = 0; k < n; k++)
    begin
      a = $urandom;
      // Three in four land in the local space to reach every device field
      if ($urandom_range(3, 0) != 0)
      begin
        a[31:24] = 8'($urandom_range(8'h4f, 0));
        a[23:20] = 4'($urandom_range(15, 0));
      end
      op = mem_op_e'(1'($urandom_range(1, 0)));
      // CLINT traffic stays reads of fixed registers
      if (ref_target(a) == 0)
      begin
        op = e_mem_rd;
        if (a[15:0] == MTIME_OFFSET)
          a[3] = 1'b0;
      end
      send_cmd(r, op, a, {$urandom, $urandom});
    end
  endtask

  task automatic wait_drain(string what);
    int n;
    n = 0;
    while (!all_done() && n < DRAIN_LIMIT)
    begin
      @(posedge clk);
      n++;
    end
    if (!all_done())
    begin
      $display("Timeout: %s did not drain", what);
      errors++;
    end
    @(negedge clk);
  endtask

  task automatic check_bit(string name, logic got, logic exp);
    checks++;
    if (got !== exp)
    begin
      $display("** Error: %s got %h expected %h", name, got, exp);
      errors++;
    end
  endtask

  task automatic check_target_cmd(mem_msg_t m, int tgt, string name);
    mem_msg_t e;
    int       r;
    r = int'(m.lce_id);
    tgt_count++;
    checks++;
    if (ref_target(m.addr) != tgt)
    begin
      $display("** Error: %s addr %h on target %0h, expected target %0h",
               name, m.addr, tgt, ref_target(m.addr));
      errors++;
    end
    else if (r >= NUM_REQ || cmd_exp[r].size() == 0)
    begin
      $display("Command on %s from requester %0d was never issued", name, r);
      errors++;
    end
    else
    begin
      e = cmd_exp[r].pop_front();
      if (m !== e)
      begin
        $display("** Error: %s got %h expected %h", name, m, e);
        errors++;
      end
    end
  endtask

  task automatic check_resp(int r, mem_msg_t m);
    mem_msg_t e;
    bit       known;
    resp_count++;
    checks++;
    last_data[r] = m.data;
    if (resp_exp[r].size() == 0)
    begin
      $display("Unexpected response on requester %0d for addr %h", r, m.addr);
      errors++;
    end
    else
    begin
      e     = resp_exp[r].pop_front();
      known = data_known[r].pop_front();
      if (!known)
        e.data = m.data;
      if (m !== e)
      begin
        $display("** Error: req_resp_o[%0d] got %h expected %h", r, m, e);
        errors++;
      end
    end
  endtask

  task automatic end_test(string name, int mark);
    for (int i = 0; i < NUM_REQ; i++)
    begin
      if (cmd_exp[i].size() != 0)
      begin
        $display("Requester %0d has commands that never reached a target", i);
        errors++;
        cmd_exp[i].delete();
      end
    end
    $display("Test %s finished with %0d errors", name, errors - mark);
  endtask

  // Compare process, sampled mid-cycle where every output is settled
  always @(negedge clk)
  begin
    cmd_fire  = req_cmd_v & req_cmd_ready;
    io_fire   = io_cmd_v & io_cmd_ready;
    mem_fire  = mem_cmd_v & mem_cmd_ready;
    io_rfire  = io_resp_v & io_resp_ready;
    mem_rfire = mem_resp_v & mem_resp_ready;
    io_cmd_s  = io_cmd;
    mem_cmd_s = mem_cmd;
    if (io_fire)
      check_target_cmd(io_cmd, 1, "io_cmd_o");
    if (mem_fire)
      check_target_cmd(mem_cmd, 2, "mem_cmd_o");
    for (int i = 0; i < NUM_REQ; i++)
    begin
      if (req_resp_v[i] && req_resp_ready[i])
        check_resp(i, req_resp[i]);
    end
  end

  // Requester drivers and the two target models
  always @(posedge clk)
  begin
    #1;
    if (resp_throttle)
      req_resp_ready = NUM_REQ'($urandom);
    else
      req_resp_ready = '1;
    for (int i = 0; i < NUM_REQ; i++)
    begin
      if (cmd_fire[i])
        void'(cmd_src[i].pop_front());
      req_cmd_v[i] = (cmd_src[i].size() != 0);
      if (req_cmd_v[i])
        req_cmd[i] = cmd_src[i][0];
    end
    if (io_rfire)
    begin
      io_resp_v = 1'b0;
      io_busy   = 1'b0;
    end
    if (io_fire)
    begin
      io_resp   = model_resp(io_cmd_s);
      io_resp_v = 1'b1;
      io_busy   = 1'b1;
    end
    if (mem_rfire)
    begin
      mem_resp_v = 1'b0;
      mem_busy   = 1'b0;
    end
    if (mem_fire)
    begin
      mem_resp   = model_resp(mem_cmd_s);
      mem_resp_v = 1'b1;
      mem_busy   = 1'b1;
    end
  end

  initial
  begin
    int     n;
    int     mark;
    int     resp_mark;
    int     tgt_mark;
    dword_t t0;
    dword_t t1;
    void'($urandom(32'h3b90));
    #1 arst_n = 1'b0;
    repeat (8) @(posedge clk);
    #1 arst_n = 1'b1;

    mark = errors;
    for (int r = 0; r < NUM_REQ; r++)
    begin
      random_cmds(r, 20);
      wait_drain("routing");
    end
    end_test("routing", mark);

    // Alternate I/O and memory so responses return from both sides
    mark = errors;
    for (int r = 0; r < NUM_REQ; r++)
    begin
      for (int k = 0; k < 8; k++)
        send_cmd(r, k[1] ? e_mem_wr : e_mem_rd,
                 k[0] ? {8'h00, HOST_DEV, 20'(r * 256 + k * 8)}
                      : 32'h8000_0000 + 32'(r * 256 + k * 8),
                 {$urandom, $urandom});
    end
    wait_drain("steering");
    end_test("steering", mark);

    mark = errors;
    resp_throttle = 1'b1;
    for (int r = 0; r < NUM_REQ; r++)
      random_cmds(r, 24);
    wait_drain("contention");
    resp_throttle = 1'b0;
    end_test("contention", mark);

    mark = errors;
    @(posedge clk);
    #1 mem_stall = 1'b1;
    resp_mark = resp_count;
    tgt_mark  = tgt_count;
    for (int r = 0; r < NUM_REQ; r++)
    begin
      send_cmd(r, e_mem_rd, 32'h9000_0000 + 32'(r * 8), '0);
      send_cmd(r, e_mem_rd, {8'h00, HOST_DEV, 20'(r * 8)}, '0);
      send_cmd(r, e_mem_rd, {CLINT_HI, MSIP_OFFSET}, '0);
    end
    repeat (30) @(posedge clk);
    checks++;
    if (resp_count != resp_mark || tgt_count != tgt_mark)
    begin
      $display("Commands completed while mem_cmd_ready_i was low");
      errors++;
    end
    #1 mem_stall = 1'b0;
    wait_drain("back-pressure");
    end_test("back-pressure", mark);

    mark = errors;
    send_cmd(0, e_mem_wr, {CLINT_HI, MSIP_OFFSET}, 64'h1);
    wait_drain("msip write");
    check_bit("software_irq_o", software_irq, 1'b1);
    send_cmd(0, e_mem_rd, {CLINT_HI, MSIP_OFFSET}, '0);
    send_cmd(0, e_mem_wr, {CLINT_HI, MSIP_OFFSET}, 64'h0);
    send_cmd(0, e_mem_rd, {CLINT_HI, MSIP_OFFSET}, '0);
    wait_drain("msip clear");
    check_bit("software_irq_o", software_irq, 1'b0);
    check_bit("timer_irq_o", timer_irq, 1'b0);
    send_cmd(1, e_mem_wr, {CLINT_HI, MTIMECMP_OFFSET}, 64'h40);
    send_cmd(1, e_mem_rd, {CLINT_HI, MTIMECMP_OFFSET}, '0);
    wait_drain("mtimecmp write");
    n = 0;
    while (!timer_irq && n < 100)
    begin
      @(negedge clk);
      n++;
    end
    check_bit("timer_irq_o", timer_irq, 1'b1);
    send_cmd(2, e_mem_rd, {CLINT_HI, MTIME_OFFSET}, '0);
    wait_drain("mtime read");
    t0 = last_data[2];
    send_cmd(2, e_mem_rd, {CLINT_HI, MTIME_OFFSET}, '0);
    wait_drain("mtime read");
    t1 = last_data[2];
    checks++;
    if (t1 <= t0)
    begin
      $display("** Error: mtime got %h after %h", t1, t0);
      errors++;
    end
    end_test("clint", mark);

    $display("Checks %0d, errors %0d, target commands %0d, responses %0d",
             checks, errors, tgt_count, resp_count);
    if (errors == 0)
      $display("Simulation PASSED");
    else
      $display("Simulation FAILED");
    $finish;
  end

endmodule

// ==== testbench/uncore_properties.sv ====
`timescale 1ns/1ps

module uncore_properties
  #(parameter int NUM_REQ = 3)
  (input  logic                                clk_i
   , input  logic                                arst_n_i
   , input  logic                                clint_cmd_v
   , input  logic                                io_cmd_v_o
   , input  logic                                mem_cmd_v_o
   , input  uncore_pkg::mem_msg_t [NUM_REQ-1:0]  queue_cmd
   , input  logic                  [NUM_REQ-1:0] queue_cmd_v
   , input  logic                  [NUM_REQ-1:0] queue_cmd_ready
   , input  logic                                clint_resp_v
   , input  logic                                clint_resp_ready
   , input  uncore_pkg::mem_msg_t                clint_resp
   , input  uncore_pkg::mem_msg_t [NUM_REQ-1:0]  req_resp_o
   , input  logic                  [NUM_REQ-1:0] req_resp_v_o
   , input  logic                  [NUM_REQ-1:0] req_resp_ready_i
   );

  one_target: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      $onehot0({clint_cmd_v, io_cmd_v_o, mem_cmd_v_o}))
    else $error("more than one target command valid");

  for (genvar i = 0; i < NUM_REQ; i++)
  begin : cmd_hold
    hold: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        queue_cmd_v[i] && !queue_cmd_ready[i] |=> queue_cmd_v[i] && $stable(queue_cmd[i]))
      else $error("queued command dropped or changed before grant");
  end

  clint_resp_hold: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      clint_resp_v && !clint_resp_ready |=> clint_resp_v && $stable(clint_resp))
    else $error("CLINT response dropped or changed before ready");

  for (genvar i = 0; i < NUM_REQ; i++)
  begin : resp_hold
    hold: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        req_resp_v_o[i] && !req_resp_ready_i[i] |=> req_resp_v_o[i] && $stable(req_resp_o[i]))
      else $error("requester response dropped or changed before ready");
  end

  // Outputs are quiet while reset is held
  quiet_in_reset: assert property (@(posedge clk_i)
      !arst_n_i |-> !(clint_cmd_v || io_cmd_v_o || mem_cmd_v_o || clint_resp_v || |req_resp_v_o))
    else $error("valid output high during reset");

endmodule

bind softcore_uncore uncore_properties #(.NUM_REQ(NUM_REQ)) props
  (.clk_i(clk_i)
   , .arst_n_i(arst_n_i)
   , .clint_cmd_v(clint_cmd_v)
   , .io_cmd_v_o(io_cmd_v_o)
   , .mem_cmd_v_o(mem_cmd_v_o)
   , .queue_cmd(queue_cmd)
   , .queue_cmd_v(queue_cmd_v)
   , .queue_cmd_ready(queue_cmd_ready)
   , .clint_resp_v(clint_resp_v)
   , .clint_resp_ready(clint_resp_ready)
   , .clint_resp(clint_resp)
   , .req_resp_o(req_resp_o)
   , .req_resp_v_o(req_resp_v_o)
   , .req_resp_ready_i(req_resp_ready_i)
   );

// ==== verilog/clint_slice.sv ====
`timescale 1ns/1ps

module clint_slice
  (input  logic                 clk_i
   , input  logic                 arst_n_i

   , input  uncore_pkg::mem_msg_t cmd_i
   , input  logic                 cmd_v_i
   , output logic                 cmd_ready_o

   , output uncore_pkg::mem_msg_t resp_o
   , output logic                 resp_v_o
   , input  logic                 resp_ready_i

   , output logic                 timer_irq_o
   , output logic                 software_irq_o
   );

  import uncore_pkg::*;

  dword_t     mtime_q;
  dword_t     mtimecmp_q;
  logic       msip_q;
  mem_msg_t   resp_q;
  logic       resp_v_q;
  logic       accept;
  logic       is_wr;
  clint_off_t offset;
  dword_t     rd_data;

  // One message in flight at a time
  assign cmd_ready_o = ~resp_v_q;
  assign accept      = cmd_v_i & cmd_ready_o;
  assign is_wr       = (cmd_i.op == e_mem_wr);
  assign offset      = cmd_i.addr[$bits(clint_off_t)-1:0];

  always_comb
  begin
    case (offset)
      MSIP_OFFSET:     rd_data = {{($bits(dword_t)-1){1'b0}}, msip_q};
      MTIMECMP_OFFSET: rd_data = mtimecmp_q;
      MTIME_OFFSET:    rd_data = mtime_q;
      default:         rd_data = '0;
    endcase
  end

  always_ff @(posedge clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      msip_q     <= 1'b0;
      mtimecmp_q <= '1;
      mtime_q    <= '0;
    end
    else
    begin
      if (accept && is_wr && offset == MSIP_OFFSET)
        msip_q <= cmd_i.data[0];
      if (accept && is_wr && offset == MTIMECMP_OFFSET)
        mtimecmp_q <= cmd_i.data;
      // Free-running unless software loads a new time
      if (accept && is_wr && offset == MTIME_OFFSET)
        mtime_q <= cmd_i.data;
      else
        mtime_q <= mtime_q + dword_t'(1);
    end
  end

  // Response held until the router takes it
  always_ff @(posedge clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
      resp_v_q <= 1'b0;
    else if (accept)
      resp_v_q <= 1'b1;
    else if (resp_ready_i)
      resp_v_q <= 1'b0;
  end

  always_ff @(posedge clk_i)
  begin
    if (accept)
    begin
      resp_q.op     <= cmd_i.op;
      resp_q.addr   <= cmd_i.addr;
      resp_q.lce_id <= cmd_i.lce_id;
      resp_q.data   <= is_wr ? cmd_i.data : rd_data;
    end
  end

  assign resp_o   = resp_q;
  assign resp_v_o = resp_v_q;

  assign software_irq_o = msip_q;
  assign timer_irq_o    = (mtime_q >= mtimecmp_q);

endmodule

// ==== verilog/mem_cmd_router.sv ====
`timescale 1ns/1ps

module mem_cmd_router
  #(parameter int NUM_REQ = 3)
  (input  uncore_pkg::mem_msg_t [NUM_REQ-1:0] cmd_i
   , input  logic                 [NUM_REQ-1:0] cmd_v_i
   , output logic                 [NUM_REQ-1:0] cmd_ready_o

   , output uncore_pkg::mem_msg_t               clint_cmd_o
   , output logic                               clint_cmd_v_o
   , input  logic                               clint_cmd_ready_i

   , output uncore_pkg::mem_msg_t               io_cmd_o
   , output logic                               io_cmd_v_o
   , input  logic                               io_cmd_ready_i

   , output uncore_pkg::mem_msg_t               mem_cmd_o
   , output logic                               mem_cmd_v_o
   , input  logic                               mem_cmd_ready_i
   );

  import uncore_pkg::*;

  logic               all_ready;
  logic [NUM_REQ-1:0] grant;
  logic               sel_v;
  mem_msg_t           sel_msg;
  logic               is_local;
  dev_id_t            dev;
  logic               is_clint;
  logic               is_io;
  logic               is_mem;

  // A stalled target blocks every requester
  assign all_ready = clint_cmd_ready_i & io_cmd_ready_i & mem_cmd_ready_i;

  // Highest valid index wins
  always_comb
  begin
    grant = '0;
    for (int i = 0; i < NUM_REQ; i++)
    begin
      if (cmd_v_i[i])
      begin
        grant    = '0;
        grant[i] = 1'b1;
      end
    end
    if (!all_ready)
      grant = '0;
  end

  always_comb
  begin
    sel_msg = '0;
    for (int i = 0; i < NUM_REQ; i++)
    begin
      if (grant[i])
        sel_msg = cmd_i[i];
    end
  end

  assign sel_v       = |grant;
  assign cmd_ready_o = grant;

  // Memory map decode on the granted address
  assign is_local = (sel_msg.addr < LOCAL_LIMIT);
  assign dev      = sel_msg.addr[DEV_LSB +: $bits(dev_id_t)];
  assign is_clint = is_local & (dev == CLINT_DEV);
  assign is_io    = is_local & (dev == HOST_DEV);
  // Cache device, the old config slot and unmapped devices all fall to memory
  assign is_mem   = ~is_clint & ~is_io;

  assign clint_cmd_o = sel_msg;
  assign io_cmd_o    = sel_msg;
  assign mem_cmd_o   = sel_msg;

  assign clint_cmd_v_o = sel_v & is_clint;
  assign io_cmd_v_o    = sel_v & is_io;
  assign mem_cmd_v_o   = sel_v & is_mem;

endmodule

// ==== verilog/mem_msg_queue.sv ====
`timescale 1ns/1ps

module mem_msg_queue
  (input  logic                 clk_i
   , input  logic                 arst_n_i

   // Requester command in, toward the command router out
   , input  uncore_pkg::mem_msg_t cmd_i
   , input  logic                 cmd_v_i
   , output logic                 cmd_ready_o
   , output uncore_pkg::mem_msg_t cmd_o
   , output logic                 cmd_v_o
   , input  logic                 cmd_ready_i

   // Routed response in, toward the requester out
   , input  uncore_pkg::mem_msg_t resp_i
   , input  logic                 resp_v_i
   , output logic                 resp_ready_o
   , output uncore_pkg::mem_msg_t resp_o
   , output logic                 resp_v_o
   , input  logic                 resp_ready_i
   );

  import uncore_pkg::*;

  // Channel 0 is the command FIFO, channel 1 the response FIFO
  mem_msg_t [1:0] push_data;
  logic     [1:0] push_v;
  logic     [1:0] push_ready;
  mem_msg_t [1:0] pop_data;
  logic     [1:0] pop_v;
  logic     [1:0] pop_ready;

  assign push_data = {resp_i, cmd_i};
  assign push_v    = {resp_v_i, cmd_v_i};
  assign pop_ready = {resp_ready_i, cmd_ready_i};

  assign {resp_ready_o, cmd_ready_o} = push_ready;
  assign {resp_o, cmd_o}             = pop_data;
  assign {resp_v_o, cmd_v_o}         = pop_v;

  for (genvar ch = 0; ch < 2; ch++)
  begin : fifo
    mem_msg_t   mem_q [2];
    logic       wr_ptr_q;
    logic       rd_ptr_q;
    logic [1:0] count_q;
    logic       push;
    logic       pop;

    assign push_ready[ch] = (count_q != 2'd2);
    assign pop_v[ch]      = (count_q != 2'd0);
    assign pop_data[ch]   = mem_q[rd_ptr_q];

    assign push = push_v[ch] & push_ready[ch];
    assign pop  = pop_v[ch] & pop_ready[ch];

    always_ff @(posedge clk_i or negedge arst_n_i)
    begin
      if (!arst_n_i)
      begin
        wr_ptr_q <= 1'b0;
        rd_ptr_q <= 1'b0;
        count_q  <= 2'd0;
      end
      else
      begin
        if (push)
          wr_ptr_q <= ~wr_ptr_q;
        if (pop)
          rd_ptr_q <= ~rd_ptr_q;
        count_q <= count_q + {1'b0, push} - {1'b0, pop};
      end
    end

    always_ff @(posedge clk_i)
    begin
      if (push)
        mem_q[wr_ptr_q] <= push_data[ch];
    end
  end

endmodule

// ==== verilog/mem_resp_router.sv ====
`timescale 1ns/1ps

module mem_resp_router
  #(parameter int NUM_REQ = 3)
  (input  uncore_pkg::mem_msg_t               clint_resp_i
   , input  logic                               clint_resp_v_i
   , output logic                               clint_resp_ready_o

   , input  uncore_pkg::mem_msg_t               io_resp_i
   , input  logic                               io_resp_v_i
   , output logic                               io_resp_ready_o

   , input  uncore_pkg::mem_msg_t               mem_resp_i
   , input  logic                               mem_resp_v_i
   , output logic                               mem_resp_ready_o

   , output uncore_pkg::mem_msg_t [NUM_REQ-1:0] resp_o
   , output logic                 [NUM_REQ-1:0] resp_v_o
   , input  logic                 [NUM_REQ-1:0] resp_ready_i
   );

  import uncore_pkg::*;

  logic     all_ready;
  logic     sel_v;
  mem_msg_t sel_msg;

  // Every requester queue must have room before anything moves
  assign all_ready = &resp_ready_i;

  // Memory first, then I/O, then CLINT
  assign mem_resp_ready_o   = all_ready & mem_resp_v_i;
  assign io_resp_ready_o    = all_ready & io_resp_v_i & ~mem_resp_v_i;
  assign clint_resp_ready_o = all_ready & clint_resp_v_i & ~mem_resp_v_i & ~io_resp_v_i;

  assign sel_v = mem_resp_ready_o | io_resp_ready_o | clint_resp_ready_o;

  always_comb
  begin
    if (mem_resp_v_i)
      sel_msg = mem_resp_i;
    else if (io_resp_v_i)
      sel_msg = io_resp_i;
    else
      sel_msg = clint_resp_i;
  end

  // Out-of-range ids match no queue and are dropped here
  for (genvar i = 0; i < NUM_REQ; i++)
  begin : steer
    assign resp_o[i]   = sel_msg;
    assign resp_v_o[i] = sel_v & (sel_msg.lce_id == lce_id_t'(i));
  end

endmodule

// ==== verilog/softcore_uncore.sv ====
`timescale 1ns/1ps

module softcore_uncore
  #(parameter int NUM_REQ = 3)
  (input  logic                               clk_i
   , input  logic                               arst_n_i

   // Requester ports: dcache engine, icache engine, incoming I/O
   , input  uncore_pkg::mem_msg_t [NUM_REQ-1:0] req_cmd_i
   , input  logic                 [NUM_REQ-1:0] req_cmd_v_i
   , output logic                 [NUM_REQ-1:0] req_cmd_ready_o
   , output uncore_pkg::mem_msg_t [NUM_REQ-1:0] req_resp_o
   , output logic                 [NUM_REQ-1:0] req_resp_v_o
   , input  logic                 [NUM_REQ-1:0] req_resp_ready_i

   // Outgoing I/O
   , output uncore_pkg::mem_msg_t               io_cmd_o
   , output logic                               io_cmd_v_o
   , input  logic                               io_cmd_ready_i
   , input  uncore_pkg::mem_msg_t               io_resp_i
   , input  logic                               io_resp_v_i
   , output logic                               io_resp_ready_o

   // Memory, also the cache target without an L2
   , output uncore_pkg::mem_msg_t               mem_cmd_o
   , output logic                               mem_cmd_v_o
   , input  logic                               mem_cmd_ready_i
   , input  uncore_pkg::mem_msg_t               mem_resp_i
   , input  logic                               mem_resp_v_i
   , output logic                               mem_resp_ready_o

   , output logic                               timer_irq_o
   , output logic                               software_irq_o
   );

  import uncore_pkg::*;

  mem_msg_t [NUM_REQ-1:0] queue_cmd;
  logic     [NUM_REQ-1:0] queue_cmd_v;
  logic     [NUM_REQ-1:0] queue_cmd_ready;
  mem_msg_t [NUM_REQ-1:0] route_resp;
  logic     [NUM_REQ-1:0] route_resp_v;
  logic     [NUM_REQ-1:0] route_resp_ready;

  mem_msg_t clint_cmd;
  logic     clint_cmd_v;
  logic     clint_cmd_ready;
  mem_msg_t clint_resp;
  logic     clint_resp_v;
  logic     clint_resp_ready;

  for (genvar i = 0; i < NUM_REQ; i++)
  begin : req_queue
    mem_msg_queue queue
      (.clk_i(clk_i)
       , .arst_n_i(arst_n_i)
       , .cmd_i(req_cmd_i[i])
       , .cmd_v_i(req_cmd_v_i[i])
       , .cmd_ready_o(req_cmd_ready_o[i])
       , .cmd_o(queue_cmd[i])
       , .cmd_v_o(queue_cmd_v[i])
       , .cmd_ready_i(queue_cmd_ready[i])
       , .resp_i(route_resp[i])
       , .resp_v_i(route_resp_v[i])
       , .resp_ready_o(route_resp_ready[i])
       , .resp_o(req_resp_o[i])
       , .resp_v_o(req_resp_v_o[i])
       , .resp_ready_i(req_resp_ready_i[i])
       );
  end

  mem_cmd_router
    #(.NUM_REQ(NUM_REQ))
    cmd_router
      (.cmd_i(queue_cmd)
       , .cmd_v_i(queue_cmd_v)
       , .cmd_ready_o(queue_cmd_ready)
       , .clint_cmd_o(clint_cmd)
       , .clint_cmd_v_o(clint_cmd_v)
       , .clint_cmd_ready_i(clint_cmd_ready)
       , .io_cmd_o(io_cmd_o)
       , .io_cmd_v_o(io_cmd_v_o)
       , .io_cmd_ready_i(io_cmd_ready_i)
       , .mem_cmd_o(mem_cmd_o)
       , .mem_cmd_v_o(mem_cmd_v_o)
       , .mem_cmd_ready_i(mem_cmd_ready_i)
       );

  mem_resp_router
    #(.NUM_REQ(NUM_REQ))
    resp_router
      (.clint_resp_i(clint_resp)
       , .clint_resp_v_i(clint_resp_v)
       , .clint_resp_ready_o(clint_resp_ready)
       , .io_resp_i(io_resp_i)
       , .io_resp_v_i(io_resp_v_i)
       , .io_resp_ready_o(io_resp_ready_o)
       , .mem_resp_i(mem_resp_i)
       , .mem_resp_v_i(mem_resp_v_i)
       , .mem_resp_ready_o(mem_resp_ready_o)
       , .resp_o(route_resp)
       , .resp_v_o(route_resp_v)
       , .resp_ready_i(route_resp_ready)
       );

  clint_slice clint
    (.clk_i(clk_i)
     , .arst_n_i(arst_n_i)
     , .cmd_i(clint_cmd)
     , .cmd_v_i(clint_cmd_v)
     , .cmd_ready_o(clint_cmd_ready)
     , .resp_o(clint_resp)
     , .resp_v_o(clint_resp_v)
     , .resp_ready_i(clint_resp_ready)
     , .timer_irq_o(timer_irq_o)
     , .software_irq_o(software_irq_o)
     );

endmodule

// ==== verilog/uncore_pkg.sv ====
package uncore_pkg;

  // Bus field widths
  typedef logic [31:0] paddr_t;
  typedef logic [63:0] dword_t;
  typedef logic [1:0]  lce_id_t;

  // Local device number and CLINT register offset
  typedef logic [3:0]  dev_id_t;
  typedef logic [15:0] clint_off_t;

  typedef enum logic
  {
    e_mem_rd = 1'b0,
    e_mem_wr = 1'b1
  } mem_op_e;

  // Same layout for commands and responses
  typedef struct packed
  {
    mem_op_e op;
    paddr_t  addr;
    lce_id_t lce_id;
    dword_t  data;
  } mem_msg_t;

  // Local memory map
  localparam paddr_t LOCAL_LIMIT = 32'h5000_0000;
  localparam int unsigned DEV_LSB = 20;

  localparam dev_id_t CLINT_DEV = 4'd1;
  localparam dev_id_t HOST_DEV  = 4'd2;
  localparam dev_id_t CACHE_DEV = 4'd3;

  // CLINT registers, low 16 bits of the address
  localparam clint_off_t MSIP_OFFSET     = 16'h0000;
  localparam clint_off_t MTIMECMP_OFFSET = 16'h4000;
  localparam clint_off_t MTIME_OFFSET    = 16'hbff8;

endpackage
